//--- rtl/mmu_pkg.sv
// Shared widths and encodings for the translation unit.
// Pages are 4 KiB and the page table is single level, indexed by the virtual page number.
`default_nettype none

package mmu_pkg;

    localparam int VA_W  = 32;
    localparam int VPN_W = 20;
    localparam int OFF_W = VA_W - VPN_W;
    localparam int PPN_W = 8;
    localparam int PA_W  = PPN_W + OFF_W;
    localparam int PTE_W = 32;

    // page table entry layout. The physical page sits in the low bits.
    localparam int PTE_VALID_BIT = 31;
    localparam int PTE_RO_BIT    = 30;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FLUSH = 2'd2
    } mmu_op_e;

    typedef enum logic [1:0] {
        FAULT_NONE = 2'd0,
        FAULT_PAGE = 2'd1,
        FAULT_PROT = 2'd2
    } mmu_fault_e;

    typedef enum logic [1:0] {
        WALK_IDLE = 2'd0,
        WALK_REQ  = 2'd1,
        WALK_WAIT = 2'd2,
        WALK_DONE = 2'd3
    } walk_state_e;

endpackage

`default_nettype wire

//--- rtl/access_decode.sv
// Request strobes that arrive while busy_i is high are dropped, not queued.
// The miss decision is combinational on the registered request and hit_i.
`timescale 1ns/1ps
`default_nettype none

module access_decode (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic                        req_valid_i,
    input  mmu_pkg::mmu_op_e                 req_op_i,
    input  wire logic [mmu_pkg::VA_W-1:0]    req_vaddr_i,
    input  wire logic                        req_super_i,
    input  wire logic                        busy_i,
    input  wire logic                        hit_i,
    output logic                             lk_valid_o,
    output mmu_pkg::mmu_op_e                 lk_op_o,
    output logic [mmu_pkg::VPN_W-1:0]        lk_vpn_o,
    output logic [mmu_pkg::OFF_W-1:0]        lk_offset_o,
    output logic                             lk_super_o,
    output logic                             lk_flush_o,
    output logic                             miss_o
);

    import mmu_pkg::*;

    logic accept;
    logic user_access;

    assign accept = req_valid_i & ~busy_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lk_valid_o <= 1'b0;
        end else begin
            lk_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            lk_op_o     <= req_op_i;
            lk_vpn_o    <= req_vaddr_i[VA_W-1:OFF_W];
            lk_offset_o <= req_vaddr_i[OFF_W-1:0];
            lk_super_o  <= req_super_i;
        end
    end

    assign lk_flush_o = lk_valid_o & (lk_op_o == OP_FLUSH);

    // only user loads and stores go through the TLB.
    assign user_access = ~lk_super_o & ((lk_op_o == OP_LOAD) | (lk_op_o == OP_STORE));
    assign miss_o      = lk_valid_o & user_access & ~hit_i;

endmodule

`default_nettype wire

//--- rtl/tlb.sv
// Lookup has no valid qualifier, so any request whose page matches an entry marks it
// most recently used, supervisor and flush requests included. TLB_ENTRIES must be 2 or more.
`timescale 1ns/1ps
`default_nettype none

module tlb #(
    parameter int TLB_ENTRIES = 2
) (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic [mmu_pkg::VPN_W-1:0]   lk_vpn_i,
    input  wire logic                        flush_i,
    input  wire logic                        fill_i,
    input  wire logic [mmu_pkg::VPN_W-1:0]   fill_vpn_i,
    input  wire logic [mmu_pkg::PPN_W-1:0]   fill_ppn_i,
    input  wire logic                        fill_ro_i,
    output logic                             hit_o,
    output logic [mmu_pkg::PPN_W-1:0]        ppn_o,
    output logic                             ro_o
);

    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] valid_q;
    logic [VPN_W-1:0]       tag_q [TLB_ENTRIES];
    logic [PPN_W-1:0]       ppn_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] ro_q;
    logic [IDX_W-1:0]       mru_q;

    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] victim;

    // the lowest matching valid entry wins.
    always_comb begin
        hit_o   = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit_o && valid_q[i] && (tag_q[i] == lk_vpn_i)) begin
                hit_o   = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
        ppn_o = hit_o ? ppn_q[hit_idx] : '0;
        ro_o  = hit_o & ro_q[hit_idx];
    end

    // Replacement picks the first free slot, otherwise the one after the MRU entry.
    // With two entries that is plain LRU.
    always_comb begin
        logic found;
        found = 1'b0;
        if (mru_q == IDX_W'(TLB_ENTRIES - 1)) begin
            victim = '0;
        end else begin
            victim = mru_q + 1'b1;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!found && !valid_q[i]) begin
                found  = 1'b1;
                victim = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            mru_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[victim] <= 1'b1;
            mru_q           <= victim;
        end else if (hit_o) begin
            mru_q <= hit_idx;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i && !flush_i) begin
            tag_q[victim] <= fill_vpn_i;
            ppn_q[victim] <= fill_ppn_i;
            ro_q[victim]  <= fill_ro_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/page_walker.sv
// One outstanding table read at a time. pte_valid_i is only taken while waiting for it.
// Entries with the valid bit clear are reported as a page fault and never filled.
`timescale 1ns/1ps
`default_nettype none

module page_walker (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic                        miss_i,
    input  wire logic [mmu_pkg::VPN_W-1:0]   vpn_i,
    input  wire logic                        pte_valid_i,
    input  wire logic [mmu_pkg::PTE_W-1:0]   pte_data_i,
    output logic                             pte_rd_o,
    output logic [mmu_pkg::VPN_W-1:0]        pte_index_o,
    output logic                             fill_o,
    output logic [mmu_pkg::VPN_W-1:0]        fill_vpn_o,
    output logic [mmu_pkg::PPN_W-1:0]        fill_ppn_o,
    output logic                             fill_ro_o,
    output logic                             done_o,
    output logic [mmu_pkg::PPN_W-1:0]        done_ppn_o,
    output logic                             done_ro_o,
    output logic                             done_fault_o,
    output logic                             idle_o
);

    import mmu_pkg::*;

    walk_state_e state_q;
    walk_state_e state_d;

    logic [VPN_W-1:0] vpn_q;
    logic [PPN_W-1:0] ppn_q;
    logic             ro_q;
    logic             pte_ok_q;
    logic             pte_take;

    assign pte_take = (state_q == WALK_WAIT) & pte_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WALK_IDLE: if (miss_i) state_d = WALK_REQ;
            WALK_REQ:  state_d = WALK_WAIT;
            WALK_WAIT: if (pte_valid_i) state_d = WALK_DONE;
            WALK_DONE: state_d = WALK_IDLE;
            default:   state_d = WALK_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WALK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == WALK_IDLE) && miss_i) begin
            vpn_q <= vpn_i;
        end
        if (pte_take) begin
            ppn_q    <= pte_data_i[PPN_W-1:0];
            ro_q     <= pte_data_i[PTE_RO_BIT];
            pte_ok_q <= pte_data_i[PTE_VALID_BIT];
        end
    end

    assign pte_rd_o    = (state_q == WALK_REQ);
    assign pte_index_o = vpn_q;

    // The TLB is written on the same edge that takes the entry.
    assign fill_o     = pte_take & pte_data_i[PTE_VALID_BIT];
    assign fill_vpn_o = vpn_q;
    assign fill_ppn_o = pte_data_i[PPN_W-1:0];
    assign fill_ro_o  = pte_data_i[PTE_RO_BIT];

    assign done_o       = (state_q == WALK_DONE);
    assign done_ppn_o   = ppn_q;
    assign done_ro_o    = ro_q;
    assign done_fault_o = ~pte_ok_q;

    assign idle_o = (state_q == WALK_IDLE);

endmodule

`default_nettype wire

//--- rtl/access_result.sv
// Responses leave one cycle after the lookup stage, or one cycle after walk completion.
// The address and fault hold their last value outside the response pulse.
`timescale 1ns/1ps
`default_nettype none

module access_result (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic                        lk_valid_i,
    input  mmu_pkg::mmu_op_e                 lk_op_i,
    input  wire logic [mmu_pkg::OFF_W-1:0]   lk_offset_i,
    input  wire logic                        lk_super_i,
    input  wire logic [mmu_pkg::PPN_W-1:0]   lk_vpn_low_i,
    input  wire logic                        miss_i,
    input  wire logic [mmu_pkg::PPN_W-1:0]   hit_ppn_i,
    input  wire logic                        hit_ro_i,
    input  wire logic                        walk_done_i,
    input  wire logic [mmu_pkg::PPN_W-1:0]   walk_ppn_i,
    input  wire logic                        walk_ro_i,
    input  wire logic                        walk_fault_i,
    output logic                             resp_valid_o,
    output logic [mmu_pkg::PA_W-1:0]         resp_paddr_o,
    output mmu_pkg::mmu_fault_e              resp_fault_o
);

    import mmu_pkg::*;

    logic [OFF_W-1:0] pend_offset_q;
    logic             pend_store_q;

    logic             resp_valid_d;
    logic [PA_W-1:0]  resp_paddr_d;
    mmu_fault_e       resp_fault_d;

    // a missing request parks its offset and store flag until the walker is done.
    always_ff @(posedge clk_i) begin
        if (miss_i) begin
            pend_offset_q <= lk_offset_i;
            pend_store_q  <= (lk_op_i == OP_STORE);
        end
    end

    always_comb begin
        resp_valid_d = 1'b0;
        resp_paddr_d = '0;
        resp_fault_d = FAULT_NONE;
        if (walk_done_i) begin
            resp_valid_d = 1'b1;
            if (walk_fault_i) begin
                resp_fault_d = FAULT_PAGE;
            end else begin
                resp_paddr_d = {walk_ppn_i, pend_offset_q};
                if (pend_store_q && walk_ro_i) begin
                    resp_fault_d = FAULT_PROT;
                end
            end
        end else if (lk_valid_i && !miss_i) begin
            resp_valid_d = 1'b1;
            if (lk_op_i == OP_FLUSH) begin
                resp_paddr_d = '0;
            end else if (lk_super_i) begin
                resp_paddr_d = {lk_vpn_low_i, lk_offset_i};
            end else begin
                resp_paddr_d = {hit_ppn_i, lk_offset_i};
                if ((lk_op_i == OP_STORE) && hit_ro_i) begin
                    resp_fault_d = FAULT_PROT;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= resp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (resp_valid_d) begin
            resp_paddr_o <= resp_paddr_d;
            resp_fault_o <= resp_fault_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mmu_top.sv
// Hits, supervisor requests and flushes answer two cycles after the strobe.
// busy_o rises the cycle after a missing request is taken and drops once the walker is idle.
`timescale 1ns/1ps
`default_nettype none

module mmu_top #(
    parameter int TLB_ENTRIES = 2
) (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic                        req_valid_i,
    input  mmu_pkg::mmu_op_e                 req_op_i,
    input  wire logic [mmu_pkg::VA_W-1:0]    req_vaddr_i,
    input  wire logic                        req_super_i,
    output logic                             resp_valid_o,
    output logic [mmu_pkg::PA_W-1:0]         resp_paddr_o,
    output mmu_pkg::mmu_fault_e              resp_fault_o,
    output logic                             busy_o,
    output logic                             pte_rd_o,
    output logic [mmu_pkg::VPN_W-1:0]        pte_index_o,
    input  wire logic                        pte_valid_i,
    input  wire logic [mmu_pkg::PTE_W-1:0]   pte_data_i
);

    import mmu_pkg::*;

    logic             lk_valid;
    mmu_op_e          lk_op;
    logic [VPN_W-1:0] lk_vpn;
    logic [OFF_W-1:0] lk_offset;
    logic             lk_super;
    logic             lk_flush;
    logic             miss;

    logic             hit;
    logic [PPN_W-1:0] hit_ppn;
    logic             hit_ro;

    logic             fill;
    logic [VPN_W-1:0] fill_vpn;
    logic [PPN_W-1:0] fill_ppn;
    logic             fill_ro;

    logic             walk_done;
    logic [PPN_W-1:0] walk_ppn;
    logic             walk_ro;
    logic             walk_fault;
    logic             walk_idle;

    assign busy_o = ~walk_idle | miss;

    access_decode u_decode (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_vaddr_i (req_vaddr_i),
        .req_super_i (req_super_i),
        .busy_i      (busy_o),
        .hit_i       (hit),
        .lk_valid_o  (lk_valid),
        .lk_op_o     (lk_op),
        .lk_vpn_o    (lk_vpn),
        .lk_offset_o (lk_offset),
        .lk_super_o  (lk_super),
        .lk_flush_o  (lk_flush),
        .miss_o      (miss)
    );

    tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .lk_vpn_i   (lk_vpn),
        .flush_i    (lk_flush),
        .fill_i     (fill),
        .fill_vpn_i (fill_vpn),
        .fill_ppn_i (fill_ppn),
        .fill_ro_i  (fill_ro),
        .hit_o      (hit),
        .ppn_o      (hit_ppn),
        .ro_o       (hit_ro)
    );

    page_walker u_walker (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .miss_i       (miss),
        .vpn_i        (lk_vpn),
        .pte_valid_i  (pte_valid_i),
        .pte_data_i   (pte_data_i),
        .pte_rd_o     (pte_rd_o),
        .pte_index_o  (pte_index_o),
        .fill_o       (fill),
        .fill_vpn_o   (fill_vpn),
        .fill_ppn_o   (fill_ppn),
        .fill_ro_o    (fill_ro),
        .done_o       (walk_done),
        .done_ppn_o   (walk_ppn),
        .done_ro_o    (walk_ro),
        .done_fault_o (walk_fault),
        .idle_o       (walk_idle)
    );

    access_result u_result (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .lk_valid_i   (lk_valid),
        .lk_op_i      (lk_op),
        .lk_offset_i  (lk_offset),
        .lk_super_i   (lk_super),
        .lk_vpn_low_i (lk_vpn[PPN_W-1:0]),
        .miss_i       (miss),
        .hit_ppn_i    (hit_ppn),
        .hit_ro_i     (hit_ro),
        .walk_done_i  (walk_done),
        .walk_ppn_i   (walk_ppn),
        .walk_ro_i    (walk_ro),
        .walk_fault_i (walk_fault),
        .resp_valid_o (resp_valid_o),
        .resp_paddr_o (resp_paddr_o),
        .resp_fault_o (resp_fault_o)
    );

endmodule

`default_nettype wire

//--- tests/pt_mem_model.sv
// Page table memory with a read latency of 1 to 4 cycles drawn from a fixed-seed LCG.
// Only one read may be pending. A new read replaces the pending one.
`timescale 1ns/1ps
`default_nettype none

module pt_mem_model (
    input  wire logic                        clk_i,
    input  wire logic                        rd_i,
    input  wire logic [mmu_pkg::VPN_W-1:0]   index_i,
    output logic                             valid_o,
    output logic [mmu_pkg::PTE_W-1:0]        data_o
);

    import mmu_pkg::*;

    localparam logic [31:0] SEED = 32'hc0f4;

    logic [31:0]      rng;
    logic [VPN_W-1:0] index_q;
    int               wait_cnt;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // valid unless the low four page bits are all ones, read-only from page bit 4.
    // The unused middle bits carry the page number so the DUT must ignore them.
    function automatic logic [PTE_W-1:0] table_entry(input logic [VPN_W-1:0] vpn);
        logic [PTE_W-1:0] pte;
        pte                = '0;
        pte[29:8]          = {2'b10, vpn};
        pte[PTE_VALID_BIT] = (vpn[3:0] != 4'hf);
        pte[PTE_RO_BIT]    = vpn[4];
        pte[PPN_W-1:0]     = vpn[7:0] ^ 8'h5a;
        return pte;
    endfunction

    initial begin
        valid_o  = 1'b0;
        data_o   = '0;
        rng      = SEED;
        index_q  = '0;
        wait_cnt = 0;
        forever begin
            @(negedge clk_i);
            if (rd_i) begin
                rng      = next_random(rng);
                index_q  = index_i;
                wait_cnt = 1 + int'(rng[31:30]);
            end
            @(posedge clk_i);
            #2;
            valid_o = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    valid_o = 1'b1;
                    data_o  = table_entry(index_q);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/mmu_tb.sv
// Expected responses come from the PTE rule and a two-entry TLB model kept in issue order.
// Hit, supervisor and flush responses are checked to the cycle, miss responses by order.
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

    import mmu_pkg::*;

    localparam int          TLB_N    = 2;
    localparam logic [31:0] SEED     = 32'hc0f4;
    localparam logic [7:0]  PPN_MASK = 8'h5a;
    localparam logic [19:0] PAGE_A   = 20'h00021;
    localparam logic [19:0] PAGE_B   = 20'h00022;
    localparam logic [19:0] PAGE_C   = 20'h00023;
    localparam logic [19:0] PAGE_BAD = 20'h0002f;
    localparam logic [19:0] PAGE_RO  = 20'h00031;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        req_valid;
    mmu_op_e     req_op;
    logic [31:0] req_vaddr;
    logic        req_super;
    logic        resp_valid;
    logic [19:0] resp_paddr;
    mmu_fault_e  resp_fault;
    logic        busy;
    logic        pte_rd;
    logic [19:0] pte_index;
    logic        pte_valid;
    logic [31:0] pte_data;

    int          cycle = 0;
    logic [19:0] exp_paddr_q[$];
    mmu_fault_e  exp_fault_q[$];
    int          exp_cyc_q[$];
    logic [19:0] rd_q[$];

    logic [TLB_N-1:0] tlb_valid = '0;
    logic [19:0]      tlb_tag[TLB_N];
    int               tlb_mru = 0;

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    mmu_top #(
        .TLB_ENTRIES (TLB_N)
    ) dut0 (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_vaddr_i  (req_vaddr),
        .req_super_i  (req_super),
        .resp_valid_o (resp_valid),
        .resp_paddr_o (resp_paddr),
        .resp_fault_o (resp_fault),
        .busy_o       (busy),
        .pte_rd_o     (pte_rd),
        .pte_index_o  (pte_index),
        .pte_valid_i  (pte_valid),
        .pte_data_i   (pte_data)
    );

    pt_mem_model mem0 (
        .clk_i   (clk),
        .rd_i    (pte_rd),
        .index_i (pte_index),
        .valid_o (pte_valid),
        .data_o  (pte_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic page_ok(input logic [19:0] vpn);
        return vpn[3:0] != 4'hf;
    endfunction

    function automatic logic [7:0] page_ppn(input logic [19:0] vpn);
        return vpn[7:0] ^ PPN_MASK;
    endfunction

    function automatic mmu_fault_e access_fault(input mmu_op_e op, input logic [19:0] vpn);
        if (op == OP_STORE && vpn[4]) begin
            return FAULT_PROT;
        end
        return FAULT_NONE;
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic push_expected(input logic [19:0] paddr, input mmu_fault_e fault,
                                 input int cyc);
        exp_paddr_q.push_back(paddr);
        exp_fault_q.push_back(fault);
        exp_cyc_q.push_back(cyc);
    endtask

    // a cycle of -1 marks a miss, whose latency depends on the table memory.
    task automatic issue(input mmu_op_e op, input logic [31:0] va, input logic sup);
        logic [19:0] vpn;
        int          guard;
        int          hit_idx;
        int          victim;
        vpn     = va[31:12];
        guard   = 0;
        hit_idx = -1;
        @(posedge clk);
        #2;
        while (busy) begin
            req_valid = 1'b0;
            guard++;
            assert (guard < 100) else begin
                $display("timed out waiting for busy_o to fall before a request");
                stop_run();
            end
            @(posedge clk);
            #2;
        end
        req_valid = 1'b1;
        req_op    = op;
        req_vaddr = va;
        req_super = sup;
        for (int i = 0; i < TLB_N; i++) begin
            if (hit_idx < 0 && tlb_valid[i] && tlb_tag[i] == vpn) begin
                hit_idx = i;
            end
        end
        if (op == OP_FLUSH) begin
            tlb_valid = '0;
            push_expected(20'h0, FAULT_NONE, cycle + 2);
        end else if (sup) begin
            // a matching entry still counts as used, even though it is bypassed.
            if (hit_idx >= 0) begin
                tlb_mru = hit_idx;
            end
            push_expected({vpn[7:0], va[11:0]}, FAULT_NONE, cycle + 2);
        end else if (hit_idx >= 0) begin
            tlb_mru = hit_idx;
            push_expected({page_ppn(vpn), va[11:0]}, access_fault(op, vpn), cycle + 2);
        end else begin
            rd_q.push_back(vpn);
            if (!page_ok(vpn)) begin
                push_expected(20'h0, FAULT_PAGE, -1);
            end else begin
                victim = (tlb_mru + 1) % TLB_N;
                for (int i = TLB_N - 1; i >= 0; i--) begin
                    if (!tlb_valid[i]) begin
                        victim = i;
                    end
                end
                tlb_valid[victim] = 1'b1;
                tlb_tag[victim]   = vpn;
                tlb_mru           = victim;
                push_expected({page_ppn(vpn), va[11:0]}, access_fault(op, vpn), -1);
            end
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        while (exp_paddr_q.size() != 0 || busy) begin
            guard++;
            assert (guard < 200) else begin
                $display("timed out waiting for outstanding responses");
                stop_run();
            end
            @(posedge clk);
            #2;
        end
        assert (rd_q.size() == 0) else begin
            $display("an expected page table read never happened");
            stop_run();
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && pte_rd) begin
            assert (rd_q.size() > 0) else begin
                $display("page table read issued with no miss outstanding");
                stop_run();
            end
            check_value("pte_index_o", 32'(rd_q.pop_front()), 32'(pte_index));
        end
        if (arst_n && resp_valid) begin
            assert (exp_paddr_q.size() > 0) else begin
                $display("response seen with no request outstanding");
                stop_run();
            end
            assert (exp_cyc_q[0] < 0 || exp_cyc_q[0] == cycle) else begin
                $display("response arrived in cycle %0d instead of cycle %0d",
                         cycle, exp_cyc_q[0]);
                stop_run();
            end
            check_value("resp_paddr_o", 32'(exp_paddr_q.pop_front()), 32'(resp_paddr));
            check_value("resp_fault_o", 32'(exp_fault_q.pop_front()), 32'(resp_fault));
            void'(exp_cyc_q.pop_front());
        end
    end

    initial begin
        mmu_op_e     op;
        logic [31:0] rng;
        logic [19:0] page;
        logic        sup;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_vaddr = '0;
        req_super = 1'b0;
        arst_n    = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        assert (!busy && !resp_valid && !pte_rd) else begin
            $display("busy_o, resp_valid_o or pte_rd_o is high after reset");
            stop_run();
        end

        // supervisor requests bypass the TLB and never read the table.
        issue(OP_LOAD, 32'habcde123, 1'b1);
        issue(OP_STORE, 32'h12345fff, 1'b1);
        drain();

        // a user miss walks once, then the same page hits.
        issue(OP_LOAD, {PAGE_A, 12'h0a4}, 1'b0);
        drain();
        issue(OP_STORE, {PAGE_A, 12'hffc}, 1'b0);
        drain();

        // A, B, A, C makes C replace B. Then A hits and B walks again.
        issue(OP_LOAD, {PAGE_B, 12'h010}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_A, 12'h020}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_C, 12'h030}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_A, 12'h040}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_B, 12'h050}, 1'b0);
        drain();

        // invalid entries fault and stay uncached, read-only pages refuse stores.
        issue(OP_LOAD, {PAGE_BAD, 12'h123}, 1'b0);
        drain();
        issue(OP_STORE, {PAGE_BAD, 12'h456}, 1'b0);
        drain();
        issue(OP_STORE, {PAGE_RO, 12'h789}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_RO, 12'habc}, 1'b0);
        drain();

        // after a flush every page has to be walked again.
        issue(OP_FLUSH, {PAGE_A, 12'h000}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_B, 12'h111}, 1'b0);
        drain();
        issue(OP_LOAD, {PAGE_RO, 12'h222}, 1'b0);
        drain();

        // Random mix. Reused pages give back-to-back hits.
        rng  = SEED;
        page = PAGE_A;
        for (int n = 0; n < 300; n++) begin
            rng = lcg_next(rng);
            if (rng[31:28] == 4'h0) begin
                op = OP_FLUSH;
            end else if (rng[27]) begin
                op = OP_STORE;
            end else begin
                op = OP_LOAD;
            end
            sup = (rng[26:24] == 3'b000);
            if (rng[23]) begin
                page = {15'h0b5c, rng[22], (rng[21] & rng[20]) ? 4'hf : {1'b0, rng[19], 2'b10}};
            end
            rng = lcg_next(rng);
            issue(op, {page, rng[31:20]}, sup);
        end
        drain();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/mmu_pkg.sv
rtl/access_decode.sv
rtl/tlb.sv
rtl/page_walker.sv
rtl/access_result.sv
rtl/mmu_top.sv
tests/pt_mem_model.sv
tests/mmu_tb.sv

//--- Makefile
SIM      ?= verilator
TOP      ?= mmu_tb
FILELIST ?= vlog.f
FLAGS    ?= --binary --timing --assert -j 0
BUILD    ?= obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
